// ==== verilog/asic_feeder_pkg.sv ====
`default_nettype none

package asic_feeder_pkg;

    // ========================================================================
    // widths
    // ========================================================================
    typedef logic [127:0] word_t;     // one chip bus word
    typedef logic [3:0]   ifcode_t;   // interface code from the chip
    typedef logic [4:0]   rom_addr_t; // pattern ROM word address
    typedef logic [3:0]   beat_t;     // burst length / beat count

    localparam int ROM_DEPTH  = 32;
    localparam int IFCODE_LSB = 18;   // code sits in data_in[21:18]
    localparam int NUM_CODES  = 8;    // codes 8..15 are unknown

    localparam string ROM_FILE = "verilog/pattern_rom.hex";

    // ========================================================================
    // interface codes
    // ========================================================================
    localparam ifcode_t IFCODE_CFG     = 4'd0;
    localparam ifcode_t IFCODE_FLGOFM  = 4'd1;
    localparam ifcode_t IFCODE_OFM     = 4'd2;
    localparam ifcode_t IFCODE_WEIADDR = 4'd3;
    localparam ifcode_t IFCODE_WEI     = 4'd4;
    localparam ifcode_t IFCODE_FLGWEI  = 4'd5;
    localparam ifcode_t IFCODE_ACT     = 4'd6;
    localparam ifcode_t IFCODE_FLGACT  = 4'd7;

    // burst length per code, in words
    localparam beat_t LEN_CFG     = 4'd2;
    localparam beat_t LEN_WEIADDR = 4'd2;
    localparam beat_t LEN_FLGWEI  = 4'd2;
    localparam beat_t LEN_WEI     = 4'd4;
    localparam beat_t LEN_FLGACT  = 4'd2;
    localparam beat_t LEN_ACT     = 4'd4;
    localparam beat_t LEN_OFM     = 4'd2;
    localparam beat_t LEN_FLGOFM  = 4'd2;

    // base address after reset, per code
    localparam rom_addr_t BASE_CFG     = 5'd0;
    localparam rom_addr_t BASE_WEIADDR = 5'd2;
    localparam rom_addr_t BASE_FLGWEI  = 5'd4;
    localparam rom_addr_t BASE_WEI     = 5'd6;
    localparam rom_addr_t BASE_FLGACT  = 5'd14;
    localparam rom_addr_t BASE_ACT     = 5'd16;
    localparam rom_addr_t BASE_OFM     = 5'd24;
    localparam rom_addr_t BASE_FLGOFM  = 5'd28;

    typedef enum logic [2:0] {
        IDLE,
        CONFIG,
        WAIT0,
        WAIT1,
        RD_DATA
    } seq_state_t;

    // zero length marks an unknown code
    function automatic beat_t len_of(input ifcode_t c);
        case (c)
            IFCODE_CFG:     return LEN_CFG;
            IFCODE_FLGOFM:  return LEN_FLGOFM;
            IFCODE_OFM:     return LEN_OFM;
            IFCODE_WEIADDR: return LEN_WEIADDR;
            IFCODE_WEI:     return LEN_WEI;
            IFCODE_FLGWEI:  return LEN_FLGWEI;
            IFCODE_ACT:     return LEN_ACT;
            IFCODE_FLGACT:  return LEN_FLGACT;
            default:        return '0;
        endcase
    endfunction

    function automatic rom_addr_t base_of(input ifcode_t c);
        case (c)
            IFCODE_CFG:     return BASE_CFG;
            IFCODE_FLGOFM:  return BASE_FLGOFM;
            IFCODE_OFM:     return BASE_OFM;
            IFCODE_WEIADDR: return BASE_WEIADDR;
            IFCODE_WEI:     return BASE_WEI;
            IFCODE_FLGWEI:  return BASE_FLGWEI;
            IFCODE_ACT:     return BASE_ACT;
            IFCODE_FLGACT:  return BASE_FLGACT;
            default:        return '0;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== verilog/request_capture.sv ====
`timescale 1ns/100ps
`default_nettype none

module request_capture (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     config_req,
    input  wire asic_feeder_pkg::word_t   data_in,
    output logic                          start,
    output asic_feeder_pkg::ifcode_t      code
);
    import asic_feeder_pkg::*;

    logic    req_q;   // sampled request
    logic    req_qq;  // previous sample, for edge detect
    ifcode_t code_q;  // code field sampled with req_q

    // input sampling
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q  <= 1'b0;
            req_qq <= 1'b0;
            code_q <= '0;
        end else begin
            req_q  <= config_req;
            req_qq <= req_q;
            code_q <= data_in[IFCODE_LSB +: $bits(ifcode_t)];
        end
    end

    // one-cycle start on rising edge of the sampled request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start <= 1'b0;
            code  <= '0;
        end else begin
            start <= req_q & ~req_qq;
            if (req_q && !req_qq) begin
                code <= code_q; // hold code of the sampled edge
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/burst_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module burst_sequencer (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       start,
    input  wire asic_feeder_pkg::ifcode_t   code,
    output logic                            rom_en,
    output asic_feeder_pkg::rom_addr_t      rom_addr,
    output logic                            beat_active
);
    import asic_feeder_pkg::*;

    seq_state_t state;
    seq_state_t next_state;

    ifcode_t    cur_code;                 // code of the running burst
    beat_t      cur_len;                  // its length
    beat_t      beat_cnt;                 // beats sent so far in RD_DATA
    beat_t      lookup_len;
    logic       accept;
    logic       last_beat;
    rom_addr_t  base_q [NUM_CODES];       // next start address per code

    // ========================================================================
    // request acceptance
    // ========================================================================
    assign lookup_len = len_of(code);

    // only from IDLE, only for known codes
    assign accept    = (state == IDLE) && start && (lookup_len != '0);
    assign last_beat = (state == RD_DATA) && (beat_cnt == cur_len - beat_t'(1));

    // ========================================================================
    // FSM
    // ========================================================================
    always_comb begin
        next_state = state;
        case (state)
            IDLE:    if (accept) next_state = CONFIG;
            CONFIG:  next_state = WAIT0;
            WAIT0:   next_state = WAIT1;
            WAIT1:   next_state = RD_DATA;
            RD_DATA: if (last_beat) next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_code <= '0;
            cur_len  <= '0;
        end else if (accept) begin
            cur_code <= code;
            cur_len  <= lookup_len;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (state == RD_DATA) begin
            beat_cnt <= beat_cnt + beat_t'(1);
        end else begin
            beat_cnt <= '0;
        end
    end

    // ========================================================================
    // base addresses
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_CODES; i++) begin
                base_q[i] <= base_of(ifcode_t'(i));
            end
        end else if (last_beat) begin
            // wraps modulo ROM_DEPTH
            base_q[cur_code[2:0]] <= base_q[cur_code[2:0]] + rom_addr_t'(cur_len);
        end
    end

    // ========================================================================
    // ROM fetch, one cycle ahead of the beats
    // ========================================================================
    assign rom_en = (state == WAIT1) || ((state == RD_DATA) && !last_beat);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rom_addr <= '0;
        end else if (state == CONFIG) begin
            rom_addr <= base_q[cur_code[2:0]];
        end else if (rom_en) begin
            rom_addr <= rom_addr + rom_addr_t'(1); // wraps at 31
        end
    end

    assign beat_active = (state == RD_DATA);

endmodule

`default_nettype wire

// ==== verilog/pattern_rom.sv ====
`timescale 1ns/100ps
`default_nettype none

module pattern_rom (
    input  wire logic                         clk,
    input  wire logic                         rom_en,
    input  wire asic_feeder_pkg::rom_addr_t   rom_addr,
    output asic_feeder_pkg::word_t            rom_data
);
    import asic_feeder_pkg::*;

    word_t mem [ROM_DEPTH];

    initial begin
        $readmemh(ROM_FILE, mem);
    end

    // registered read, holds while disabled
    always_ff @(posedge clk) begin
        if (rom_en) begin
            rom_data <= mem[rom_addr];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/chip_driver.sv ====
`timescale 1ns/100ps
`default_nettype none

module chip_driver (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     beat_active,
    input  wire asic_feeder_pkg::word_t   rom_data,
    output asic_feeder_pkg::word_t        data_out,
    output logic                          cs_n,
    output logic                          oe_n
);
    import asic_feeder_pkg::*;

    logic beat_d; // beat_active one cycle back, for the oe tail

    // ========================================================================
    // launch on the falling edge, half a cycle ahead of the chip sample
    // ========================================================================
    always_ff @(negedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cs_n   <= 1'b1;
            beat_d <= 1'b0;
        end else begin
            cs_n   <= ~beat_active;
            beat_d <= beat_active;
        end
    end

    always_ff @(negedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_out <= '0;
        end else if (beat_active) begin
            data_out <= rom_data;
        end
    end

    // oe held one extra cycle so the pad can turn around
    always_ff @(negedge clk or negedge rst_n) begin
        if (!rst_n) begin
            oe_n <= 1'b1;
        end else begin
            oe_n <= ~(beat_active | beat_d);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/asic_feeder_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module asic_feeder_top (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     config_req,
    input  wire asic_feeder_pkg::word_t   data_in,
    output asic_feeder_pkg::word_t        data_out,
    output logic                          cs_n,
    output logic                          oe_n
);
    import asic_feeder_pkg::*;

    logic      start;
    ifcode_t   code;
    logic      rom_en;
    rom_addr_t rom_addr;
    word_t     rom_data;
    logic      beat_active;

    // ========================================================================
    // input side
    // ========================================================================
    request_capture u_request_capture (
        .clk        (clk),
        .rst_n      (rst_n),
        .config_req (config_req),
        .data_in    (data_in),
        .start      (start),
        .code       (code)
    );

    // ========================================================================
    // sequencer and pattern store
    // ========================================================================
    burst_sequencer u_burst_sequencer (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .code        (code),
        .rom_en      (rom_en),
        .rom_addr    (rom_addr),
        .beat_active (beat_active)
    );

    pattern_rom u_pattern_rom (
        .clk      (clk),
        .rom_en   (rom_en),
        .rom_addr (rom_addr),
        .rom_data (rom_data)
    );

    // ========================================================================
    // output side
    // ========================================================================
    chip_driver u_chip_driver (
        .clk         (clk),
        .rst_n       (rst_n),
        .beat_active (beat_active),
        .rom_data    (rom_data),
        .data_out    (data_out),
        .cs_n        (cs_n),
        .oe_n        (oe_n)
    );

endmodule

`default_nettype wire

// ==== sim/feeder_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module feeder_checker (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     config_req,
    input  wire asic_feeder_pkg::word_t   data_in,
    input  wire asic_feeder_pkg::word_t   data_out,
    input  wire logic                     cs_n,
    input  wire logic                     oe_n,
    output int                            tests_done,
    output int                            errors
);
    import asic_feeder_pkg::*;

    word_t rom [ROM_DEPTH];
    // indexed by code, zero length for 8..15
    int    burst_len [16] = '{2, 2, 2, 2, 4, 2, 4, 2, 0, 0, 0, 0, 0, 0, 0, 0};
    int    base      [16] = '{0, 28, 24, 2, 6, 4, 16, 14, 0, 0, 0, 0, 0, 0, 0, 0};
    logic  req_prev;
    logic  busy;
    int    edge_no;       // rising edges since the request was sampled
    int    last_edge;
    int    cur_code;
    int    test_errs;
    logic  exp_cs_n;
    logic  exp_oe_n;

    initial begin
        $readmemh(ROM_FILE, rom);
    end

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s in test %0d, edge %0d: got %h, expected %h",
                     name, tests_done + 1, edge_no, got, exp);
            test_errs++;
            errors++;
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAILED %s in test %0d, edge %0d: got %h, expected %h",
                     name, tests_done + 1, edge_no, got, exp);
            test_errs++;
            errors++;
        end
    endtask

    task automatic finish_test();
        $display("test %0d: code %0h, base %0d, %0d beats, %0d errors",
                 tests_done + 1, cur_code, base[cur_code], burst_len[cur_code], test_errs);
        base[cur_code] = (base[cur_code] + burst_len[cur_code]) % ROM_DEPTH;
        tests_done++;
        busy = 1'b0;
    endtask

    // ========================================================================
    // per-edge prediction, outputs settle at the falling edge
    // ========================================================================
    always @(posedge clk) begin
        if (!rst_n) begin
            req_prev = 1'b0;
            busy     = 1'b0;
        end else begin
            exp_cs_n = 1'b1;
            exp_oe_n = 1'b1;
            if (busy) begin
                edge_no++;
                if (edge_no >= 6 && edge_no < 6 + burst_len[cur_code])
                    exp_cs_n = 1'b0;
                if (burst_len[cur_code] > 0 && edge_no >= 6
                    && edge_no <= 6 + burst_len[cur_code])
                    exp_oe_n = 1'b0; // one edge past the last beat
            end
            check_bit("cs_n", cs_n, exp_cs_n);
            check_bit("oe_n", oe_n, exp_oe_n);
            if (!exp_cs_n) begin
                check_word("data_out", data_out,
                           rom[(base[cur_code] + edge_no - 6) % ROM_DEPTH]);
            end else if (!busy && tests_done == 0) begin
                check_word("data_out", data_out, '0); // nothing sent yet
            end
            if (busy && edge_no == last_edge) finish_test();

            if (config_req && !req_prev) begin
                if (busy) begin
                    $display("test %0d: a new request came while a burst was still running",
                             tests_done + 1);
                    errors++;
                end else begin
                    cur_code  = int'(data_in[IFCODE_LSB +: $bits(ifcode_t)]);
                    // unknown codes are watched over the whole would-be window
                    last_edge = (burst_len[cur_code] > 0) ? 7 + burst_len[cur_code] : 10;
                    edge_no   = 0;
                    test_errs = 0;
                    busy      = 1'b1;
                end
            end
            req_prev = config_req;
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_asic_feeder.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_asic_feeder;
    import asic_feeder_pkg::*;

    logic    clk;
    logic    rst_n;
    logic    config_req;
    word_t   data_in;
    word_t   data_out;
    logic    cs_n;
    logic    oe_n;
    int      tests_done;
    int      errors;

    ifcode_t test_code [$];
    int      test_gap [$];
    integer  seed;
    int      cycle_cnt;
    int      cycle_limit;   // zero until the tests are read
    word_t   stim;

    asic_feeder_top u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .config_req (config_req),
        .data_in    (data_in),
        .data_out   (data_out),
        .cs_n       (cs_n),
        .oe_n       (oe_n)
    );

    feeder_checker u_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .config_req (config_req),
        .data_in    (data_in),
        .data_out   (data_out),
        .cs_n       (cs_n),
        .oe_n       (oe_n),
        .tests_done (tests_done),
        .errors     (errors)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic read_tests();
        int    fd;
        int    c;
        int    g;
        string line;
        fd = $fopen("sim/feeder_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the tests file sim/feeder_tests.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // skip column notes and blank lines
                if (line.len() > 0 && line[0] != "#" && $sscanf(line, "%h %d", c, g) == 2) begin
                    test_code.push_back(ifcode_t'(c));
                    test_gap.push_back(g);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic random_word(output word_t w);
        for (int i = 0; i < 4; i++) begin
            w[i*32 +: 32] = $random(seed);
        end
    endtask

    // ========================================================================
    // run limit
    // ========================================================================
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycle_cnt);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        int total_gap;
        seed        = 32'ha059;
        rst_n       = 1'b0;
        config_req  = 1'b0;
        data_in     = '0;
        cycle_limit = 0;
        total_gap   = 0;
        read_tests();
        foreach (test_gap[i]) begin
            total_gap += test_gap[i];
        end
        cycle_limit = total_gap + 20 * test_gap.size();

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (4) @(negedge clk); // idle time with outputs at reset values

        foreach (test_code[i]) begin
            random_word(stim);
            stim[IFCODE_LSB +: $bits(ifcode_t)] = test_code[i];
            data_in    = stim;
            config_req = 1'b1;
            @(negedge clk);
            config_req = 1'b0;
            random_word(stim);
            data_in    = stim; // code field only valid with the request
            repeat (test_gap[i]) @(negedge clk);
        end
        repeat (2) @(negedge clk);

        $display("summary: %0d of %0d tests finished, %0d errors",
                 tests_done, test_code.size(), errors);
        if (test_code.size() > 0 && tests_done == test_code.size() && errors == 0) begin
            $display("Everything OK");
        end else begin
            if (tests_done != test_code.size() || test_code.size() == 0)
                $display("not every request in the tests file led to a finished test");
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/pattern_rom.hex ====
// one 128-bit word per line, ROM address 0 first, 31 last
00ffa5005aff0f00c3003cff960069ff
01fea5015afe0f01c3013cfe960169fe
02fda5025afd0f02c3023cfd960269fd
03fca5035afc0f03c3033cfc960369fc
04fba5045afb0f04c3043cfb960469fb
05faa5055afa0f05c3053cfa960569fa
06f9a5065af90f06c3063cf9960669f9
07f8a5075af80f07c3073cf8960769f8
08f7a5085af70f08c3083cf7960869f7
09f6a5095af60f09c3093cf6960969f6
0af5a50a5af50f0ac30a3cf5960a69f5
0bf4a50b5af40f0bc30b3cf4960b69f4
0cf3a50c5af30f0cc30c3cf3960c69f3
0df2a50d5af20f0dc30d3cf2960d69f2
0ef1a50e5af10f0ec30e3cf1960e69f1
0ff0a50f5af00f0fc30f3cf0960f69f0
10efa5105aef0f10c3103cef961069ef
11eea5115aee0f11c3113cee961169ee
12eda5125aed0f12c3123ced961269ed
13eca5135aec0f13c3133cec961369ec
14eba5145aeb0f14c3143ceb961469eb
15eaa5155aea0f15c3153cea961569ea
16e9a5165ae90f16c3163ce9961669e9
17e8a5175ae80f17c3173ce8961769e8
18e7a5185ae70f18c3183ce7961869e7
19e6a5195ae60f19c3193ce6961969e6
1ae5a51a5ae50f1ac31a3ce5961a69e5
1be4a51b5ae40f1bc31b3ce4961b69e4
1ce3a51c5ae30f1cc31c3ce3961c69e3
1de2a51d5ae20f1dc31d3ce2961d69e2
1ee1a51e5ae10f1ec31e3ce1961e69e1
1fe0a51f5ae00f1fc31f3ce0961f69e0

// ==== sim/feeder_tests.txt ====
# interface code (hex)   idle gap after the request (cycles, decimal)
# codes 8 to f are unknown and must not start a burst
0 12
3 12
5 14
4 12
7 12
6 12
2 12
1 12
9 12
4 12
1 12
1 15
f 12
0 12

// ==== asic_feeder.f ====
verilog/asic_feeder_pkg.sv
verilog/request_capture.sv
verilog/burst_sequencer.sv
verilog/pattern_rom.sv
verilog/chip_driver.sv
verilog/asic_feeder_top.sv
sim/feeder_checker.sv
sim/tb_asic_feeder.sv

// ==== Makefile ====
TOP = tb_asic_feeder

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/100ps -f asic_feeder.f --top-module $(TOP)

sim:
	verilator --binary --timing --timescale 1ns/100ps -f asic_feeder.f \
		--top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log
